/* src/asi_dump_pkg.sv */
`default_nettype none

package asi_dump_pkg;

	// one 8b10b symbol as delivered by the deserializer
	localparam int symbol_width = 10;

	localparam int dump_word_width = 32;
	localparam int symbols_per_word = dump_word_width / symbol_width;
	localparam int pad_width = dump_word_width - symbols_per_word * symbol_width;

	// K28.5 comma in both running disparities
	localparam logic [symbol_width-1:0] k28p5_pos = 10'b0101111100;
	localparam logic [symbol_width-1:0] k28p5_neg = 10'b1010000011;

	localparam int fifo_addr_width = 4;
	localparam int fifo_depth = 1 << fifo_addr_width;

	localparam int stat_width = 16; // every statistics counter has this width

	// a dump word seen either as one raw word or as its symbol slots
	typedef union packed {
		logic [dump_word_width-1:0] raw;
		struct packed {
			logic [pad_width-1:0]    pad;   // always zero
			logic [symbol_width-1:0] slot2;
			logic [symbol_width-1:0] slot1;
			logic [symbol_width-1:0] slot0; // first symbol of the word
		} slots;
	} dump_word_u;

endpackage

`default_nettype wire

/* src/asi_symbol_packer.sv */
`timescale 1ns/10ps
`default_nettype none

module asi_symbol_packer
	import asi_dump_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       ce,
	input  logic [symbol_width-1:0]    ts_data,
	input  logic                       flush,
	output logic                       word_wen,
	output logic [dump_word_width-1:0] word_data,
	output logic                       comma_seen
);

	dump_word_u pack_q; // symbols gathered so far for the current word
	dump_word_u pack_d;
	logic [1:0] slot_idx; // also the number of pending symbols
	logic [1:0] fill_d;
	logic       is_comma;
	logic       take;
	logic       emit;

	// word waiting one cycle before it goes out with word_wen
	logic                       ready;
	logic [dump_word_width-1:0] ready_word;

	always_comb begin
		is_comma = (ts_data == k28p5_pos) || (ts_data == k28p5_neg);
		take = ce && !is_comma;

		pack_d = pack_q;
		fill_d = slot_idx;
		if (take) begin
			case (slot_idx)
				2'd0: pack_d.slots.slot0 = ts_data;
				2'd1: pack_d.slots.slot1 = ts_data;
				default: pack_d.slots.slot2 = ts_data;
			endcase
			fill_d = slot_idx + 2'd1;
		end

		// a flush counts the symbol sampled at the same edge as pending
		emit = (take && (slot_idx == 2'(symbols_per_word - 1))) ||
			(flush && (fill_d != 2'd0));
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pack_q <= '0;
			slot_idx <= 2'd0;
			ready <= 1'b0;
		end else begin
			ready <= emit;
			if (emit) begin
				// unused slots are already zero since the buffer starts clear
				pack_q <= '0;
				slot_idx <= 2'd0;
			end else begin
				pack_q <= pack_d;
				slot_idx <= fill_d;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			ready_word <= pack_d.raw;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			word_wen <= 1'b0;
			word_data <= '0;
			comma_seen <= 1'b0;
		end else begin
			word_wen <= ready;
			if (ready) begin
				word_data <= ready_word;
			end
			comma_seen <= ce && is_comma; // one pulse per comma, buffer untouched
		end
	end

endmodule

`default_nettype wire

/* src/asi_dump_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module asi_dump_fifo
	import asi_dump_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       wen,
	input  logic [dump_word_width-1:0] wdata,
	input  logic                       ren,
	output logic [dump_word_width-1:0] rdata,
	output logic                       rvalid,
	output logic                       empty,
	output logic                       full,
	output logic                       drop
);

	logic [dump_word_width-1:0] mem [fifo_depth];

	logic [fifo_addr_width-1:0] wr_ptr;
	logic [fifo_addr_width-1:0] rd_ptr;
	logic [fifo_addr_width:0]   count; // one bit wider so 16 fits
	logic                       do_wr;
	logic                       do_rd;

	assign empty = (count == '0);
	assign full = (count == (fifo_addr_width + 1)'(fifo_depth));

	// a read frees the slot in the same cycle, so a full FIFO still takes the word
	assign do_rd = ren && !empty;
	assign do_wr = wen && (!full || do_rd);

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rdata <= '0;
			rvalid <= 1'b0;
			drop <= 1'b0;
		end else begin
			rvalid <= do_rd;
			drop <= wen && !do_wr;

			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end

			if (do_rd) begin
				rdata <= mem[rd_ptr]; // old contents even when wr_ptr points here too
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/asi_dump_stats.sv */
`timescale 1ns/10ps
`default_nettype none

module asi_dump_stats
	import asi_dump_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  comma_seen,
	input  logic                  word_written,
	input  logic                  drop,
	output logic [stat_width-1:0] comma_count,
	output logic [stat_width-1:0] word_count,
	output logic [stat_width-1:0] drop_count
);

	// counts up on a pulse and holds at all ones
	function automatic logic [stat_width-1:0] sat_inc(
		input logic [stat_width-1:0] value,
		input logic                  pulse
	);
		logic [stat_width-1:0] result;
		result = value;
		if (pulse && (value != '1)) begin
			result = value + 1'b1;
		end
		return result;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			comma_count <= '0;
			word_count <= '0;
			drop_count <= '0;
		end else begin
			comma_count <= sat_inc(comma_count, comma_seen);
			word_count <= sat_inc(word_count, word_written); // stored and dropped words alike
			drop_count <= sat_inc(drop_count, drop);
		end
	end

endmodule

`default_nettype wire

/* src/asi_dump_top.sv */
`timescale 1ns/10ps
`default_nettype none

module asi_dump_top
	import asi_dump_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       ce,
	input  logic [symbol_width-1:0]    ts_data,
	input  logic                       flush,
	input  logic                       dump_rd,
	output logic [dump_word_width-1:0] dump_data,
	output logic                       dump_data_valid,
	output logic                       dump_empty,
	output logic                       dump_full,
	output logic [stat_width-1:0]      comma_count,
	output logic [stat_width-1:0]      word_count,
	output logic [stat_width-1:0]      drop_count
);

	logic                       word_wen;
	logic [dump_word_width-1:0] word_data;
	logic                       comma_seen;
	logic                       drop;

	asi_symbol_packer asi_symbol_packer_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.ce         (ce),
		.ts_data    (ts_data),
		.flush      (flush),
		.word_wen   (word_wen),
		.word_data  (word_data),
		.comma_seen (comma_seen)
	);

	// words go straight in, a full FIFO loses them and reports it on drop
	asi_dump_fifo asi_dump_fifo_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.wen    (word_wen),
		.wdata  (word_data),
		.ren    (dump_rd),
		.rdata  (dump_data),
		.rvalid (dump_data_valid),
		.empty  (dump_empty),
		.full   (dump_full),
		.drop   (drop)
	);

	asi_dump_stats asi_dump_stats_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.comma_seen   (comma_seen),
		.word_written (word_wen),
		.drop         (drop),
		.comma_count  (comma_count),
		.word_count   (word_count),
		.drop_count   (drop_count)
	);

endmodule

`default_nettype wire

/* tb/asi_dump_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module asi_dump_properties
	import asi_dump_pkg::*;
(
	input logic                     clk,
	input logic                     rst_n,
	input logic                     wen,
	input logic                     ren,
	input logic                     empty,
	input logic                     full,
	input logic                     drop,
	input logic                     rvalid,
	input logic [fifo_addr_width:0] count
);

	occupancy_limit: assert property (@(posedge clk) disable iff (!rst_n)
		count <= (fifo_addr_width + 1)'(fifo_depth))
		else $error("FIFO occupancy above its depth");

	empty_full_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(empty && full))
		else $error("FIFO empty and full at once");

	// drop is registered, so the write it reports came one edge earlier
	drop_cause: assert property (@(posedge clk) disable iff (!rst_n)
		drop |-> $past(wen && full))
		else $error("drop without a write to a full FIFO");

	rvalid_cause: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid |-> $past(ren && !empty))
		else $error("rvalid without a read of a non-empty FIFO");

endmodule

bind asi_dump_fifo asi_dump_properties fifo_props_i (
	.clk    (clk),
	.rst_n  (rst_n),
	.wen    (wen),
	.ren    (ren),
	.empty  (empty),
	.full   (full),
	.drop   (drop),
	.rvalid (rvalid),
	.count  (count)
);

`default_nettype wire

/* tb/asi_dump_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module asi_dump_tb
	import asi_dump_pkg::*;
();

	logic                       clk;
	logic                       rst_n;
	logic                       ce;
	logic [symbol_width-1:0]    ts_data;
	logic                       flush;
	logic                       dump_rd;
	logic [dump_word_width-1:0] dump_data;
	logic                       dump_data_valid;
	logic                       dump_empty;
	logic                       dump_full;
	logic [stat_width-1:0]      comma_count;
	logic [stat_width-1:0]      word_count;
	logic [stat_width-1:0]      drop_count;

	logic [symbol_width-1:0]    pend_q[$]; // data symbols of the word being built
	logic [dump_word_width-1:0] exp_q[$];  // words the FIFO should hand out
	int                         exp_commas;
	int                         exp_words;
	int                         exp_drops;
	int                         model_fill; // words the model thinks the FIFO holds
	integer                     seed;

	asi_dump_top asi_dump_top_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.ce              (ce),
		.ts_data         (ts_data),
		.flush           (flush),
		.dump_rd         (dump_rd),
		.dump_data       (dump_data),
		.dump_data_valid (dump_data_valid),
		.dump_empty      (dump_empty),
		.dump_full       (dump_full),
		.comma_count     (comma_count),
		.word_count      (word_count),
		.drop_count      (drop_count)
	);

	always #2 clk = ~clk;

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("error at %0t: %s", $time, reason);
		$display("Testbench failed");
		$fatal(1);
	endtask

	function automatic logic is_comma_code(input logic [symbol_width-1:0] sym);
		return (sym == k28p5_pos) || (sym == k28p5_neg);
	endfunction

	function automatic logic [symbol_width-1:0] random_data();
		logic [symbol_width-1:0] sym;
		sym = symbol_width'($random(seed));
		if (is_comma_code(sym)) begin
			sym = sym ^ 10'h001;
		end
		return sym;
	endfunction

	// slot0 takes the first symbol, missing slots and pad stay zero
	task automatic model_emit();
		logic [dump_word_width-1:0] word;
		word = '0;
		foreach (pend_q[k]) begin
			word[k*symbol_width +: symbol_width] = pend_q[k];
		end
		pend_q.delete();
		exp_words++;
		if (model_fill == fifo_depth) begin
			exp_drops++; // full and nobody reading
		end else begin
			exp_q.push_back(word);
			model_fill++;
		end
	endtask

	task automatic drive_cycle(input logic en, input logic [symbol_width-1:0] sym,
		input logic fl);
		@(posedge clk);
		ce <= en;
		ts_data <= sym;
		flush <= fl;
		if (en && is_comma_code(sym)) begin
			exp_commas++;
		end else if (en) begin
			pend_q.push_back(sym);
			if (pend_q.size() == symbols_per_word) begin
				model_emit();
			end
		end
		if (fl && (pend_q.size() != 0)) begin
			model_emit(); // a symbol sampled with the flush belongs to the partial word
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			drive_cycle(1'b0, '0, 1'b0);
		end
	endtask

	task automatic check_counters();
		@(negedge clk);
		compare_value("comma_count", comma_count, exp_commas);
		compare_value("word_count", word_count, exp_words);
		compare_value("drop_count", drop_count, exp_drops);
	endtask

	task automatic drain_fifo();
		dump_word_u                 got;
		logic [dump_word_width-1:0] expected;
		int                         reads;
		int                         wait_cycles;
		reads = 0;
		@(negedge clk);
		while (!dump_empty) begin
			if (reads > fifo_depth) begin
				abort_run("FIFO never went empty while draining");
			end
			@(posedge clk);
			dump_rd <= 1'b1;
			@(posedge clk);
			dump_rd <= 1'b0;
			wait_cycles = 0;
			@(negedge clk);
			while (!dump_data_valid) begin
				if (wait_cycles > 8) begin
					abort_run("no dump_data_valid after a read strobe");
				end
				wait_cycles++;
				@(negedge clk);
			end
			reads++;
			model_fill--;
			got.raw = dump_data;
			if (exp_q.size() == 0) begin
				abort_run("DUT returned a word the model did not expect");
			end
			expected = exp_q.pop_front();
			compare_value("dump_data slot0", got.slots.slot0, expected[9:0]);
			compare_value("dump_data slot1", got.slots.slot1, expected[19:10]);
			compare_value("dump_data slot2", got.slots.slot2, expected[29:20]);
			compare_value("dump_data pad", got.slots.pad, expected[31:30]);
		end
		compare_value("words left in model", exp_q.size(), 0);
	endtask

	task automatic read_when_empty();
		@(posedge clk);
		dump_rd <= 1'b1;
		@(posedge clk);
		dump_rd <= 1'b0;
		repeat (3) begin
			@(negedge clk);
			compare_value("dump_data_valid", dump_data_valid, 1'b0);
		end
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		compare_value("dump_empty", dump_empty, 1'b1);
		compare_value("dump_full", dump_full, 1'b0);
		compare_value("dump_data_valid", dump_data_valid, 1'b0);
		compare_value("dump_data", dump_data, 0);
		check_counters();
	endtask

	task automatic test_three_words();
		for (int i = 0; i < 9; i++) begin
			drive_cycle(1'b1, 10'h100 + 10'(i), 1'b0);
		end
		idle(6);
		check_counters();
		compare_value("word_count", word_count, 3);
		drain_fifo();
	endtask

	task automatic test_commas();
		logic [symbol_width-1:0] seq [9];
		seq = '{10'h011, k28p5_pos, 10'h022, 10'h033, k28p5_neg,
			10'h044, 10'h055, k28p5_pos, 10'h066};
		foreach (seq[i]) begin
			drive_cycle(1'b1, seq[i], 1'b0);
		end
		idle(6);
		check_counters();
		drain_fifo();
	endtask

	task automatic test_flush();
		drive_cycle(1'b1, 10'h0a1, 1'b0);
		drive_cycle(1'b0, '0, 1'b1);
		idle(2);
		drive_cycle(1'b1, 10'h0b2, 1'b0);
		drive_cycle(1'b1, 10'h0c3, 1'b1);
		idle(2);
		drive_cycle(1'b0, '0, 1'b1); // nothing pending here
		idle(6);
		check_counters();
		drain_fifo();
	endtask

	task automatic test_overflow();
		for (int i = 0; i < 18 * symbols_per_word; i++) begin
			drive_cycle(1'b1, 10'h200 + 10'(i), 1'b0);
		end
		idle(6);
		check_counters();
		compare_value("dump_full", dump_full, 1'b1);
		compare_value("drop_count", drop_count, 2);
		drain_fifo();
		compare_value("dump_full", dump_full, 1'b0);
		read_when_empty();
	endtask

	task automatic test_random_stream();
		int unsigned             r;
		logic [symbol_width-1:0] sym;
		for (int i = 0; i < 300; i++) begin
			r = $unsigned($random(seed));
			if ((r % 5) == 0) begin
				drive_cycle(1'b0, '0, (r % 35) == 0);
			end
			r = $unsigned($random(seed));
			if ((r % 10) == 0) begin
				sym = r[7] ? k28p5_pos : k28p5_neg;
			end else begin
				sym = random_data();
			end
			drive_cycle(1'b1, sym, ((r % 10) == 3) && (r[9:8] == 2'd0));
			if ((i % 30) == 29) begin
				idle(6);
				drain_fifo();
			end
		end
		drive_cycle(1'b0, '0, 1'b1); // push out the tail
		idle(6);
		check_counters();
		drain_fifo();
	endtask

	initial begin
		seed = 32'h7233_6903;
		exp_commas = 0;
		exp_words = 0;
		exp_drops = 0;
		model_fill = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		ce = 1'b0;
		ts_data = '0;
		flush = 1'b0;
		dump_rd = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		test_reset_state();
		test_three_words();
		test_commas();
		test_flush();
		test_overflow();
		test_random_stream();

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
src/asi_dump_pkg.sv
src/asi_symbol_packer.sv
src/asi_dump_fifo.sv
src/asi_dump_stats.sv
src/asi_dump_top.sv
tb/asi_dump_properties.sv
tb/asi_dump_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module asi_dump_tb -o asi_dump_sim

sim_out=$(./obj_dir/asi_dump_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "Testbench passed"; then
	exit 0
else
	exit 1
fi
